//--- logic/slice_pkg.sv
package slice_pkg;

  parameter int addr_width_gp  = 32;
  parameter int dword_width_gp = 64;

  typedef enum logic [1:0] {
    mem_rd = 2'b00,
    mem_wr = 2'b01
  } mem_msg_type_e;

  // Code is log2 of the byte count
  typedef enum logic [2:0] {
    size_8   = 3'd3,
    size_16  = 3'd4,
    size_32  = 3'd5,
    size_64  = 3'd6,
    size_128 = 3'd7
  } msg_size_e;

  typedef struct packed {
    mem_msg_type_e              msg_type;
    logic [addr_width_gp-1:0]   addr;
    logic [dword_width_gp-1:0]  data;
  } mem_msg_s;

  typedef struct packed {
    mem_msg_type_e             msg_type;
    msg_size_e                 size;
    logic [addr_width_gp-1:0]  addr;
  } mem_hdr_s;

  typedef enum logic {
    op_ld = 1'b0,
    op_sd = 1'b1
  } cache_op_e;

  typedef struct packed {
    cache_op_e                  opcode;
    logic [addr_width_gp-1:0]   addr;
    logic [dword_width_gp-1:0]  data;
  } cache_pkt_s;

  // Address is always block aligned
  typedef struct packed {
    logic                      write_not_read;
    logic [addr_width_gp-1:0]  addr;
  } dma_pkt_s;

  function automatic msg_size_e block_size_code(input int unsigned words);
    msg_size_e code;
    if (words >= 16) begin
      code = size_128;
    end else if (words >= 8) begin
      code = size_64;
    end else if (words >= 4) begin
      code = size_32;
    end else if (words >= 2) begin
      code = size_16;
    end else begin
      code = size_8;
    end
    return code;
  endfunction

endpackage

//--- logic/cache_req_if.sv
`timescale 1ns/1ps

interface cache_req_if;

  // Packet channel, valid/ready
  slice_pkg::cache_pkt_s                 pkt;
  logic                                  v;
  logic                                  ready;

  // Returned data channel, valid/yumi
  logic [slice_pkg::dword_width_gp-1:0]  data;
  logic                                  data_v;
  logic                                  yumi;

  modport adapter (
    output pkt,
    output v,
    input  ready,
    input  data,
    input  data_v,
    output yumi
  );

  modport cache (
    input  pkt,
    input  v,
    output ready,
    output data,
    output data_v,
    input  yumi
  );

endinterface

//--- logic/mem_cmd_to_cache.sv
`timescale 1ns/1ps

module mem_cmd_to_cache (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  slice_pkg::mem_msg_s  mem_cmd_i,
  input  logic                 mem_cmd_v_i,
  output logic                 mem_cmd_ready_o,

  output slice_pkg::mem_msg_s  mem_resp_o,
  output logic                 mem_resp_v_o,
  input  logic                 mem_resp_yumi_i,

  cache_req_if.adapter         cache_o
);

  typedef enum logic [1:0] {
    s_idle,
    s_send,
    s_wait,
    s_resp
  } state_e;

  state_e                                state_r;
  state_e                                state_n;
  slice_pkg::mem_msg_s                   cmd_r;
  logic [slice_pkg::dword_width_gp-1:0]  resp_data_r;
  logic                                  cmd_is_wr;

  assign cmd_is_wr = (cmd_r.msg_type == slice_pkg::mem_wr);

  // Only one command in flight, so the adapter takes a new one only when idle
  always_comb begin
    state_n = state_r;
    case (state_r)
      s_idle: begin
        if (mem_cmd_v_i) begin
          state_n = s_send;
        end
      end
      s_send: begin
        if (cache_o.ready) begin
          state_n = s_wait;
        end
      end
      s_wait: begin
        if (cache_o.data_v) begin
          state_n = s_resp;
        end
      end
      s_resp: begin
        if (mem_resp_yumi_i) begin
          state_n = s_idle;
        end
      end
      default: state_n = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= s_idle;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_cmd_ready_o && mem_cmd_v_i) begin
      cmd_r <= mem_cmd_i;
    end
    // Store ack carries no data
    if (cache_o.yumi) begin
      resp_data_r <= cmd_is_wr ? '0 : cache_o.data;
    end
  end

  assign mem_cmd_ready_o = (state_r == s_idle);

  assign cache_o.v   = (state_r == s_send);
  assign cache_o.pkt = '{
    opcode: cmd_is_wr ? slice_pkg::op_sd : slice_pkg::op_ld,
    addr:   cmd_r.addr,
    data:   cmd_r.data
  };
  assign cache_o.yumi = (state_r == s_wait) && cache_o.data_v;

  assign mem_resp_v_o = (state_r == s_resp);
  assign mem_resp_o   = '{
    msg_type: cmd_r.msg_type,
    addr:     cmd_r.addr,
    data:     resp_data_r
  };

endmodule

//--- logic/slice_cache.sv
`timescale 1ns/1ps

module slice_cache #(
  parameter int sets_p        = 16,
  parameter int block_words_p = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  cache_req_if.cache                            req_i,

  output slice_pkg::dma_pkt_s                   dma_pkt_o,
  output logic                                  dma_pkt_v_o,
  input  logic                                  dma_pkt_yumi_i,

  input  logic [slice_pkg::dword_width_gp-1:0]  dma_data_i,
  input  logic                                  dma_data_v_i,
  output logic                                  dma_data_ready_o,

  output logic [slice_pkg::dword_width_gp-1:0]  dma_data_o,
  output logic                                  dma_data_v_o,
  input  logic                                  dma_data_yumi_i
);

  localparam int byte_bits_lp   = $clog2(slice_pkg::dword_width_gp / 8);
  localparam int word_bits_lp   = $clog2(block_words_p);
  localparam int index_bits_lp  = $clog2(sets_p);
  localparam int offset_bits_lp = byte_bits_lp + word_bits_lp;
  localparam int tag_bits_lp    = slice_pkg::addr_width_gp - index_bits_lp - offset_bits_lp;

  typedef enum logic [2:0] {
    s_idle,
    s_lookup,
    s_wb_hdr,
    s_wb_data,
    s_rd_hdr,
    s_fill,
    s_done
  } state_e;

  state_e                                state_r;
  state_e                                state_n;
  slice_pkg::cache_pkt_s                 pkt_r;
  logic [word_bits_lp-1:0]               cnt_r;
  logic [slice_pkg::dword_width_gp-1:0]  data_r;

  logic [tag_bits_lp-1:0]                tag_mem [sets_p];
  logic [sets_p-1:0]                     valid_r;
  logic [sets_p-1:0]                     dirty_r;
  logic [slice_pkg::dword_width_gp-1:0]  data_mem [sets_p][block_words_p];

  logic [index_bits_lp-1:0]              idx;
  logic [word_bits_lp-1:0]               word;
  logic [tag_bits_lp-1:0]                tag;
  logic [tag_bits_lp-1:0]                dma_tag;
  logic                                  hit;
  logic                                  last_beat;
  logic                                  fill_beat;
  logic                                  store_hit;

  assign idx       = pkt_r.addr[offset_bits_lp +: index_bits_lp];
  assign word      = pkt_r.addr[byte_bits_lp +: word_bits_lp];
  assign tag       = pkt_r.addr[slice_pkg::addr_width_gp-1 -: tag_bits_lp];
  assign hit       = valid_r[idx] && (tag_mem[idx] == tag);
  assign last_beat = (cnt_r == word_bits_lp'(block_words_p - 1));
  assign fill_beat = (state_r == s_fill) && dma_data_v_i;
  assign store_hit = (state_r == s_lookup) && hit && (pkt_r.opcode == slice_pkg::op_sd);

  // After a refill the FSM goes back to lookup, which then hits
  always_comb begin
    state_n = state_r;
    case (state_r)
      s_idle: begin
        if (req_i.v) begin
          state_n = s_lookup;
        end
      end
      s_lookup: begin
        if (hit) begin
          state_n = s_done;
        end else if (valid_r[idx] && dirty_r[idx]) begin
          state_n = s_wb_hdr;
        end else begin
          state_n = s_rd_hdr;
        end
      end
      s_wb_hdr: begin
        if (dma_pkt_yumi_i) begin
          state_n = s_wb_data;
        end
      end
      s_wb_data: begin
        if (dma_data_yumi_i && last_beat) begin
          state_n = s_rd_hdr;
        end
      end
      s_rd_hdr: begin
        if (dma_pkt_yumi_i) begin
          state_n = s_fill;
        end
      end
      s_fill: begin
        if (fill_beat && last_beat) begin
          state_n = s_lookup;
        end
      end
      s_done: begin
        if (req_i.yumi) begin
          state_n = s_idle;
        end
      end
      default: state_n = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= s_idle;
      cnt_r   <= '0;
      valid_r <= '0;
      dirty_r <= '0;
    end else begin
      state_r <= state_n;
      if ((state_r == s_wb_hdr) || (state_r == s_rd_hdr)) begin
        cnt_r <= '0;
      end else if (((state_r == s_wb_data) && dma_data_yumi_i) || fill_beat) begin
        cnt_r <= cnt_r + 1'b1;
      end
      if (fill_beat && last_beat) begin
        valid_r[idx] <= 1'b1;
        dirty_r[idx] <= 1'b0;
      end
      if (store_hit) begin
        dirty_r[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.v && req_i.ready) begin
      pkt_r <= req_i.pkt;
    end
    if (fill_beat) begin
      data_mem[idx][cnt_r] <= dma_data_i;
    end
    if (fill_beat && last_beat) begin
      tag_mem[idx] <= tag;
    end
    if ((state_r == s_lookup) && hit) begin
      if (store_hit) begin
        data_mem[idx][word] <= pkt_r.data;
        data_r              <= '0;
      end else begin
        data_r <= data_mem[idx][word];
      end
    end
  end

  assign req_i.ready  = (state_r == s_idle);
  assign req_i.data   = data_r;
  assign req_i.data_v = (state_r == s_done);

  // Victim tag for a writeback, request tag for a refill
  assign dma_tag     = (state_r == s_wb_hdr) ? tag_mem[idx] : tag;
  assign dma_pkt_v_o = (state_r == s_wb_hdr) || (state_r == s_rd_hdr);
  assign dma_pkt_o   = '{
    write_not_read: (state_r == s_wb_hdr),
    addr:           {dma_tag, idx, {offset_bits_lp{1'b0}}}
  };

  assign dma_data_o       = data_mem[idx][cnt_r];
  assign dma_data_v_o     = (state_r == s_wb_data);
  assign dma_data_ready_o = (state_r == s_fill);

endmodule

//--- logic/cache_slice.sv
`timescale 1ns/1ps

module cache_slice #(
  parameter int sets_p        = 16,
  parameter int block_words_p = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  input  slice_pkg::mem_msg_s                   mem_cmd_i,
  input  logic                                  mem_cmd_v_i,
  output logic                                  mem_cmd_ready_o,

  output slice_pkg::mem_msg_s                   mem_resp_o,
  output logic                                  mem_resp_v_o,
  input  logic                                  mem_resp_yumi_i,

  output slice_pkg::mem_hdr_s                   mem_cmd_header_o,
  output logic                                  mem_cmd_header_v_o,
  input  logic                                  mem_cmd_header_yumi_i,

  output logic [slice_pkg::dword_width_gp-1:0]  mem_cmd_data_o,
  output logic                                  mem_cmd_data_v_o,
  input  logic                                  mem_cmd_data_yumi_i,

  input  slice_pkg::mem_hdr_s                   mem_resp_header_i,
  input  logic                                  mem_resp_header_v_i,
  output logic                                  mem_resp_header_ready_o,

  input  logic [slice_pkg::dword_width_gp-1:0]  mem_resp_data_i,
  input  logic                                  mem_resp_data_v_i,
  output logic                                  mem_resp_data_ready_o
);

  localparam slice_pkg::msg_size_e block_size_lp = slice_pkg::block_size_code(block_words_p);

  slice_pkg::dma_pkt_s  dma_pkt;
  logic                 dma_pkt_v;

  cache_req_if i_req ();

  mem_cmd_to_cache i_adapter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_cmd_i       (mem_cmd_i),
    .mem_cmd_v_i     (mem_cmd_v_i),
    .mem_cmd_ready_o (mem_cmd_ready_o),
    .mem_resp_o      (mem_resp_o),
    .mem_resp_v_o    (mem_resp_v_o),
    .mem_resp_yumi_i (mem_resp_yumi_i),
    .cache_o         (i_req.adapter)
  );

  slice_cache #(
    .sets_p        (sets_p),
    .block_words_p (block_words_p)
  ) i_cache (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_i            (i_req.cache),
    .dma_pkt_o        (dma_pkt),
    .dma_pkt_v_o      (dma_pkt_v),
    .dma_pkt_yumi_i   (mem_cmd_header_yumi_i),
    .dma_data_i       (mem_resp_data_i),
    .dma_data_v_i     (mem_resp_data_v_i),
    .dma_data_ready_o (mem_resp_data_ready_o),
    .dma_data_o       (mem_cmd_data_o),
    .dma_data_v_o     (mem_cmd_data_v_o),
    .dma_data_yumi_i  (mem_cmd_data_yumi_i)
  );

  assign mem_cmd_header_o = '{
    msg_type: dma_pkt.write_not_read ? slice_pkg::mem_wr : slice_pkg::mem_rd,
    size:     block_size_lp,
    addr:     dma_pkt.addr
  };
  assign mem_cmd_header_v_o = dma_pkt_v;

  // Responses only answer our own commands, so headers are always taken
  // and their content (mem_resp_header_i, mem_resp_header_v_i) is ignored
  assign mem_resp_header_ready_o = 1'b1;

endmodule

//--- dv/dram_model.sv
`timescale 1ns/1ps

module dram_model #(
  parameter int block_words_p = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Bit 0 stalls header yumi, bit 1 stalls writeback data yumi
  input  logic [1:0]           hold_i,

  input  slice_pkg::mem_hdr_s  cmd_header_i,
  input  logic                 cmd_header_v_i,
  output logic                 cmd_header_yumi_o,

  input  logic [63:0]          cmd_data_i,
  input  logic                 cmd_data_v_i,
  output logic                 cmd_data_yumi_o,

  output slice_pkg::mem_hdr_s  resp_header_o,
  output logic                 resp_header_v_o,

  output logic [63:0]          resp_data_o,
  output logic                 resp_data_v_o,
  input  logic                 resp_data_ready_i
);

  // Sparse backing store, untouched words follow the address rule
  logic [63:0]  mem [logic [31:0]];
  logic [31:0]  wb_addr;
  logic [31:0]  fill_addr;
  int           wb_cnt;
  int           fill_cnt;

  function automatic logic [63:0] read_word(input logic [31:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {32'h0, a} ^ 64'h5a5a_0000_0000_0000;
  endfunction

  initial begin
    cmd_header_yumi_o <= 1'b0;
    cmd_data_yumi_o   <= 1'b0;
    resp_header_o     <= '0;
    resp_header_v_o   <= 1'b0;
    resp_data_o       <= '0;
    resp_data_v_o     <= 1'b0;
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_header_yumi_o <= 1'b0;
      cmd_data_yumi_o   <= 1'b0;
      resp_header_v_o   <= 1'b0;
      resp_data_v_o     <= 1'b0;
      wb_cnt            <= 0;
      fill_cnt          <= 0;
    end else begin
      // Valid is held until yumi, so yumi can follow a valid seen at this edge
      cmd_header_yumi_o <= cmd_header_v_i && !cmd_header_yumi_o && !hold_i[0];
      cmd_data_yumi_o   <= cmd_data_v_i && !cmd_data_yumi_o && !hold_i[1];
      resp_header_v_o   <= 1'b0;
      if (cmd_header_v_i && cmd_header_yumi_o) begin
        resp_header_o   <= cmd_header_i;
        resp_header_v_o <= 1'b1;
        if (cmd_header_i.msg_type == slice_pkg::mem_wr) begin
          wb_addr <= cmd_header_i.addr;
          wb_cnt  <= 0;
        end else begin
          fill_addr     <= cmd_header_i.addr;
          fill_cnt      <= 0;
          resp_data_o   <= read_word(cmd_header_i.addr);
          resp_data_v_o <= 1'b1;
        end
      end
      if (cmd_data_v_i && cmd_data_yumi_o) begin
        mem[wb_addr + 32'(wb_cnt * 8)] = cmd_data_i;
        wb_cnt <= wb_cnt + 1;
      end
      if (resp_data_v_o && resp_data_ready_i) begin
        if (fill_cnt == block_words_p - 1) begin
          resp_data_v_o <= 1'b0;
        end else begin
          fill_cnt    <= fill_cnt + 1;
          resp_data_o <= read_word(fill_addr + 32'((fill_cnt + 1) * 8));
        end
      end
    end
  end

endmodule

//--- dv/cache_slice_tb.sv
`timescale 1ns/1ps

module cache_slice_tb;

  localparam int          words_lp   = 4;
  localparam int          timeout_lp = 200;
  localparam logic [31:0] seed_lp    = 32'hacd3_9807;

  logic                 clk;
  logic                 rst_n;
  slice_pkg::mem_msg_s  mem_cmd_i;
  logic                 mem_cmd_v_i;
  logic                 mem_cmd_ready_o;
  slice_pkg::mem_msg_s  mem_resp_o;
  logic                 mem_resp_v_o;
  logic                 mem_resp_yumi_i;
  slice_pkg::mem_hdr_s  mem_cmd_header_o;
  logic                 mem_cmd_header_v_o;
  logic                 mem_cmd_header_yumi_i;
  logic [63:0]          mem_cmd_data_o;
  logic                 mem_cmd_data_v_o;
  logic                 mem_cmd_data_yumi_i;
  slice_pkg::mem_hdr_s  mem_resp_header_i;
  logic                 mem_resp_header_v_i;
  logic                 mem_resp_header_ready_o;
  logic [63:0]          mem_resp_data_i;
  logic                 mem_resp_data_v_i;
  logic                 mem_resp_data_ready_o;

  logic [1:0]           hold;
  logic                 gaps_on;
  logic                 aborted;
  logic [31:0]          rng;
  logic [31:0]          gap_rng;
  int                   errors;
  int                   checks;
  logic [63:0]          ref_mem [logic [31:0]];
  slice_pkg::mem_hdr_s  hdr_q [$];
  logic [63:0]          wb_q [$];
  logic                 hdr_pend;
  logic                 data_pend;
  slice_pkg::mem_hdr_s  hdr_held;
  logic [63:0]          data_held;

  cache_slice #(
    .sets_p        (16),
    .block_words_p (words_lp)
  ) i_dut (
    .clk_i                   (clk),
    .rst_n_i                 (rst_n),
    .mem_cmd_i               (mem_cmd_i),
    .mem_cmd_v_i             (mem_cmd_v_i),
    .mem_cmd_ready_o         (mem_cmd_ready_o),
    .mem_resp_o              (mem_resp_o),
    .mem_resp_v_o            (mem_resp_v_o),
    .mem_resp_yumi_i         (mem_resp_yumi_i),
    .mem_cmd_header_o        (mem_cmd_header_o),
    .mem_cmd_header_v_o      (mem_cmd_header_v_o),
    .mem_cmd_header_yumi_i   (mem_cmd_header_yumi_i),
    .mem_cmd_data_o          (mem_cmd_data_o),
    .mem_cmd_data_v_o        (mem_cmd_data_v_o),
    .mem_cmd_data_yumi_i     (mem_cmd_data_yumi_i),
    .mem_resp_header_i       (mem_resp_header_i),
    .mem_resp_header_v_i     (mem_resp_header_v_i),
    .mem_resp_header_ready_o (mem_resp_header_ready_o),
    .mem_resp_data_i         (mem_resp_data_i),
    .mem_resp_data_v_i       (mem_resp_data_v_i),
    .mem_resp_data_ready_o   (mem_resp_data_ready_o)
  );

  dram_model #(
    .block_words_p (words_lp)
  ) i_mem (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .hold_i            (hold),
    .cmd_header_i      (mem_cmd_header_o),
    .cmd_header_v_i    (mem_cmd_header_v_o),
    .cmd_header_yumi_o (mem_cmd_header_yumi_i),
    .cmd_data_i        (mem_cmd_data_o),
    .cmd_data_v_i      (mem_cmd_data_v_o),
    .cmd_data_yumi_o   (mem_cmd_data_yumi_i),
    .resp_header_o     (mem_resp_header_i),
    .resp_header_v_o   (mem_resp_header_v_i),
    .resp_data_o       (mem_resp_data_i),
    .resp_data_v_o     (mem_resp_data_v_i),
    .resp_data_ready_i (mem_resp_data_ready_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // 23 tag bits, 4 index bits, 2 word bits, 3 byte bits
  function automatic logic [31:0] addr_of(input int tg, input int st, input int wd);
    return {tg[22:0], st[3:0], wd[1:0], 3'b000};
  endfunction

  function automatic logic [63:0] ref_read(input logic [31:0] a);
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return {32'h0, a} ^ 64'h5a5a_0000_0000_0000;
  endfunction

  // Four dword blocks are 32 bytes
  function automatic slice_pkg::mem_hdr_s make_hdr(input slice_pkg::mem_msg_type_e t,
                                                   input logic [31:0] a);
    slice_pkg::mem_hdr_s h;
    h.msg_type = t;
    h.size     = slice_pkg::size_32;
    h.addr     = a;
    return h;
  endfunction

  function automatic bit traffic_ok(input int n_hdr, input int n_wb);
    if (aborted) begin
      return 1'b0;
    end
    if ((hdr_q.size() != n_hdr) || (wb_q.size() != n_wb)) begin
      errors++;
      $display("saw %0d command headers and %0d writeback beats, expected %0d and %0d",
               hdr_q.size(), wb_q.size(), n_hdr, n_wb);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic compare_msg(input string name, input slice_pkg::mem_msg_s exp,
                             input slice_pkg::mem_msg_s act);
    if (aborted) return;
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_hdr(input string name, input slice_pkg::mem_hdr_s exp,
                             input slice_pkg::mem_hdr_s act);
    if (aborted) return;
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_dword(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    if (aborted) return;
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (aborted) return;
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    if (aborted) return;
    aborted = 1'b1;
    errors++;
    $display("timeout at %0t: %s did not rise within %0d cycles", $time, what, timeout_lp);
  endtask

  // Logs outgoing traffic and checks that anything held without yumi stays stable
  always @(posedge clk) begin
    if (hdr_pend) begin
      compare_bit("mem_cmd_header_v_o", 1'b1, mem_cmd_header_v_o);
      compare_hdr("mem_cmd_header_o", hdr_held, mem_cmd_header_o);
    end
    if (data_pend) begin
      compare_bit("mem_cmd_data_v_o", 1'b1, mem_cmd_data_v_o);
      compare_dword("mem_cmd_data_o", data_held, mem_cmd_data_o);
    end
    if (mem_cmd_header_v_o && mem_cmd_header_yumi_i) begin
      hdr_q.push_back(mem_cmd_header_o);
    end
    if (mem_cmd_data_v_o && mem_cmd_data_yumi_i) begin
      wb_q.push_back(mem_cmd_data_o);
    end
    if (mem_resp_header_v_i) begin
      compare_bit("mem_resp_header_ready_o", 1'b1, mem_resp_header_ready_o);
    end
    // Fill beats only follow a read header, while the cache waits for them
    if (mem_resp_data_v_i) begin
      compare_bit("mem_resp_data_ready_o", 1'b1, mem_resp_data_ready_o);
    end
    hdr_pend  = rst_n && mem_cmd_header_v_o && !mem_cmd_header_yumi_i;
    hdr_held  = mem_cmd_header_o;
    data_pend = rst_n && mem_cmd_data_v_o && !mem_cmd_data_yumi_i;
    data_held = mem_cmd_data_o;
  end

  always @(posedge clk) begin
    if (gaps_on) begin
      gap_rng = xorshift(gap_rng);
      hold <= gap_rng[1:0];
    end else begin
      hold <= 2'b00;
    end
  end

  // Sends one command and checks its response against the scoreboard
  task automatic do_cmd(input slice_pkg::mem_msg_type_e t, input logic [31:0] a,
                        input logic [63:0] d, output int lat);
    slice_pkg::mem_msg_s exp;
    slice_pkg::mem_msg_s held;
    int                  n;
    lat = 0;
    if (aborted) return;
    exp.msg_type = t;
    exp.addr     = a;
    exp.data     = (t == slice_pkg::mem_wr) ? 64'h0 : ref_read(a);
    if (t == slice_pkg::mem_wr) begin
      ref_mem[a] = d;
    end
    mem_cmd_i   <= '{msg_type: t, addr: a, data: d};
    mem_cmd_v_i <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!mem_cmd_ready_o && (n < timeout_lp));
    mem_cmd_v_i <= 1'b0;
    if (!mem_cmd_ready_o) begin
      report_timeout("mem_cmd_ready_o");
      return;
    end
    do begin
      @(posedge clk);
      lat++;
    end while (!mem_resp_v_o && (lat < timeout_lp));
    if (!mem_resp_v_o) begin
      report_timeout("mem_resp_v_o");
      return;
    end
    held = mem_resp_o;
    compare_msg("mem_resp_o", exp, held);
    rng = xorshift(rng);
    n = 0;
    while (gaps_on && rng[0] && (n < 4)) begin
      @(posedge clk);
      compare_bit("mem_resp_v_o", 1'b1, mem_resp_v_o);
      compare_msg("mem_resp_o", held, mem_resp_o);
      rng = xorshift(rng);
      n++;
    end
    mem_resp_yumi_i <= 1'b1;
    @(posedge clk);
    compare_bit("mem_resp_v_o", 1'b1, mem_resp_v_o);
    mem_resp_yumi_i <= 1'b0;
  endtask

  task automatic clear_traffic();
    hdr_q.delete();
    wb_q.delete();
  endtask

  task automatic reset_and_first_miss();
    int lat;
    compare_bit("mem_resp_v_o", 1'b0, mem_resp_v_o);
    compare_bit("mem_cmd_header_v_o", 1'b0, mem_cmd_header_v_o);
    compare_bit("mem_cmd_data_v_o", 1'b0, mem_cmd_data_v_o);
    compare_bit("mem_cmd_ready_o", 1'b1, mem_cmd_ready_o);
    compare_bit("mem_resp_header_ready_o", 1'b1, mem_resp_header_ready_o);
    clear_traffic();
    do_cmd(slice_pkg::mem_rd, addr_of(1, 2, 1), 64'h0, lat);
    if (traffic_ok(1, 0)) begin
      compare_hdr("mem_cmd_header_o", make_hdr(slice_pkg::mem_rd, addr_of(1, 2, 0)), hdr_q[0]);
    end
  endtask

  task automatic store_then_load();
    int lat;
    clear_traffic();
    do_cmd(slice_pkg::mem_wr, addr_of(1, 2, 2), 64'h0123_4567_89ab_cdef, lat);
    do_cmd(slice_pkg::mem_rd, addr_of(1, 2, 2), 64'h0, lat);
    if (!aborted && (lat != 4)) begin
      errors++;
      $display("hit load answered %0d cycles after acceptance instead of 4", lat);
    end
    void'(traffic_ok(0, 0));
  endtask

  // Old block goes out first, then the new one is fetched
  task automatic check_eviction(input logic [31:0] old_blk, input logic [31:0] new_blk);
    int i;
    if (traffic_ok(2, words_lp)) begin
      compare_hdr("mem_cmd_header_o", make_hdr(slice_pkg::mem_wr, old_blk), hdr_q[0]);
      compare_hdr("mem_cmd_header_o", make_hdr(slice_pkg::mem_rd, new_blk), hdr_q[1]);
      for (i = 0; i < words_lp; i++) begin
        compare_dword("mem_cmd_data_o", ref_read(old_blk + 32'(i * 8)), wb_q[i]);
      end
    end
  endtask

  task automatic dirty_eviction();
    int lat;
    clear_traffic();
    do_cmd(slice_pkg::mem_rd, addr_of(2, 2, 0), 64'h0, lat);
    check_eviction(addr_of(1, 2, 0), addr_of(2, 2, 0));
  endtask

  task automatic clean_eviction();
    int lat;
    do_cmd(slice_pkg::mem_rd, addr_of(3, 5, 0), 64'h0, lat);
    clear_traffic();
    do_cmd(slice_pkg::mem_rd, addr_of(4, 5, 1), 64'h0, lat);
    if (traffic_ok(1, 0)) begin
      compare_hdr("mem_cmd_header_o", make_hdr(slice_pkg::mem_rd, addr_of(4, 5, 0)), hdr_q[0]);
    end
  endtask

  task automatic back_pressure();
    int lat;
    gaps_on <= 1'b1;
    do_cmd(slice_pkg::mem_wr, addr_of(5, 7, 1), 64'hfeed_face_cafe_0001, lat);
    clear_traffic();
    do_cmd(slice_pkg::mem_rd, addr_of(6, 7, 3), 64'h0, lat);
    check_eviction(addr_of(5, 7, 0), addr_of(6, 7, 0));
    do_cmd(slice_pkg::mem_rd, addr_of(5, 7, 1), 64'h0, lat);
  endtask

  task automatic random_sequence();
    int                        i;
    int                        lat;
    logic [31:0]               r;
    logic [63:0]               d;
    slice_pkg::mem_msg_type_e  t;
    for (i = 0; i < 40; i++) begin
      rng = xorshift(rng);
      r   = rng;
      rng = xorshift(rng);
      d   = {rng, r};
      t   = r[0] ? slice_pkg::mem_wr : slice_pkg::mem_rd;
      do_cmd(t, addr_of(8 + int'(r[9:8] % 2'd3), int'(r[3:2]), int'(r[5:4])), d, lat);
    end
  endtask

  initial begin
    rst_n           <= 1'b0;
    mem_cmd_i       <= '0;
    mem_cmd_v_i     <= 1'b0;
    mem_resp_yumi_i <= 1'b0;
    gaps_on         <= 1'b0;
    hold            <= 2'b00;
    aborted   = 1'b0;
    errors    = 0;
    checks    = 0;
    rng       = seed_lp;
    gap_rng   = seed_lp;
    hdr_pend  = 1'b0;
    data_pend = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    reset_and_first_miss();
    store_then_load();
    dirty_eviction();
    clean_eviction();
    back_pressure();
    random_sequence();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- cache_slice.f
logic/slice_pkg.sv
logic/cache_req_if.sv
logic/mem_cmd_to_cache.sv
logic/slice_cache.sv
logic/cache_slice.sv
dv/dram_model.sv
dv/cache_slice_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module cache_slice_tb -f cache_slice.f -o cache_slice_sim

output=$(./obj_dir/cache_slice_sim)
echo "$output"

if echo "$output" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi
